//--- flist.f
design/io_pkg.sv
design/io_ctrl.sv
design/irq_ctrl.sv
design/io_timers.sv
design/keypad.sv
design/gba_io_top.sv
tb/tb_gba_io.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and judge the result from sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_gba_io \
    -f flist.f -Mdir obj_dir -o sim_gba_io || exit 1

./obj_dir/sim_gba_io > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log

grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0

//--- tb/tb_gba_io.sv
// directed testbench for the I/O register block, inputs driven on the falling edge
// outputs are sampled on the falling edge, bus reads always use word accesses
// every wait is bounded, a watchdog stops the run if a test hangs
`timescale 1ns/1ps

module tb_gba_io
    import io_pkg::*;
();

    localparam int RESET_CYC    = 30;
    localparam int BE_CYC       = 40;
    localparam int TIMER_CYC    = 200;
    localparam int IRQ_CYC      = 80;
    localparam int KEY_CYC      = 150;
    localparam int MARGIN_CYC   = 100;
    localparam int WATCHDOG_CYC = RESET_CYC + BE_CYC + TIMER_CYC + IRQ_CYC + KEY_CYC + MARGIN_CYC;
    localparam int DONE_LIMIT   = 4;     // cycles to wait for bus_done

    logic                clk16;
    logic                resetn;
    logic                bus_ena;
    logic                bus_rnw;
    logic [ADDR_W-1:0]   bus_adr;
    logic [1:0]          bus_acc;
    logic [DATA_W-1:0]   bus_din;
    logic [NUM_KEYS-1:0] keys;
    logic                vblank;
    logic                hblank;
    logic                bus_done;
    logic [DATA_W-1:0]   bus_dout;
    logic                gba_on;
    logic                cpu_irq;
    logic                halt;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'hd906;

    gba_io_top i_dut (.*);

    initial begin
        clk16 = 1'b0;
        forever #4 clk16 = ~clk16;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk16);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYC);
        $display("tests failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] timer_word(input logic [15:0] reload, input logic [1:0] psc,
                                               input logic casc, input logic irqen);
        logic [31:0] w;
        w = {16'h0000, reload};
        w[TM_PRESCALE_LSB +: 2] = psc;
        w[TM_CASCADE_BIT]       = casc;
        w[TM_IRQEN_BIT]         = irqen;
        w[TM_ENABLE_BIT]        = 1'b1;      // always started
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk16);
    endtask

    task automatic run_access(input logic rnw, input logic [1:0] acc, input logic [ADDR_W-1:0] adr,
                              input logic [DATA_W-1:0] din, output logic [DATA_W-1:0] dout);
        int n;
        @(negedge clk16);
        bus_ena = 1'b1;
        bus_rnw = rnw;
        bus_acc = acc;
        bus_adr = adr;
        bus_din = din;
        @(negedge clk16);
        bus_ena = 1'b0;
        n = 0;
        while (!bus_done && n < DONE_LIMIT) begin
            @(negedge clk16);
            n++;
        end
        dout = bus_dout;
        if (!bus_done)
            report_problem($sformatf("no bus_done for the access at offset %h", adr));
    endtask

    task automatic bus_write(input logic [1:0] acc, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] din);
        logic [DATA_W-1:0] unused;
        run_access(1'b0, acc, adr, din, unused);
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] dout);
        run_access(1'b1, ACC_WORD, adr, '0, dout);
    endtask

    task automatic pulse_line(input logic use_hblank);
        @(negedge clk16);
        if (use_hblank)
            hblank = 1'b1;
        else
            vblank = 1'b1;
        @(negedge clk16);
        vblank = 1'b0;
        hblank = 1'b0;
    endtask

    // reads the flag word until the given flag shows up
    task automatic poll_flag(input int bit_no, input int max_reads, output logic seen);
        logic [31:0] rd;
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < max_reads) begin
            bus_read(IE_IF_ADDR, rd);
            seen = rd[16 + bit_no];
            n++;
        end
    endtask

    task automatic clear_flags();
        bus_write(ACC_WORD, IE_IF_ADDR, 32'hFFFF_0000);   // IE to zero, all flags cleared
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests

    task automatic reset_and_power_on();
        logic [31:0] rd;
        int n;
        resetn = 1'b0;
        wait_cycles(3);
        check("reset gba_on", 0, gba_on);
        check("reset bus_done", 0, bus_done);
        check("reset cpu_irq", 0, cpu_irq);
        check("reset halt", 0, halt);
        resetn = 1'b1;
        n = 0;
        while (!gba_on && n < RESET_HOLD + 2) begin
            @(negedge clk16);
            n++;
        end
        if (!gba_on)
            report_problem("gba_on did not rise after reset release");
        wait_cycles(2);                      // datapaths leave reset one cycle later
        bus_read(IE_IF_ADDR, rd);
        check("reset ie_if", 0, rd);
    endtask

    task automatic byte_enable_lanes();
        logic [31:0] r;
        logic [31:0] rd;
        logic [13:0] ie_exp;
        logic [7:0]  b;
        logic [15:0] h;
        r = next_rand();
        bus_write(ACC_WORD, IE_IF_ADDR, r);
        ie_exp = r[13:0];
        bus_read(IE_IF_ADDR, rd);
        check("be word", 32'(ie_exp), rd);
        r = next_rand();
        b = r[7:0];
        bus_write(ACC_BYTE, ADDR_W'(IE_IF_ADDR + 1), {8'hA5, 8'h5A, b, 8'hC3}); // lane 1 only
        ie_exp[13:8] = b[5:0];
        bus_read(IE_IF_ADDR, rd);
        check("be byte 0x201", 32'(ie_exp), rd);
        pulse_line(1'b0);                    // a set flag shows that lanes 2,3 stay untouched
        r = next_rand();
        h = r[15:0];
        bus_write(ACC_HALF, IE_IF_ADDR, {16'hFFFF, h});
        bus_read(IE_IF_ADDR, rd);
        check("be half 0x200", (32'h1 << (16 + IRQ_VBLANK)) | 32'(h[13:0]), rd);
        clear_flags();
    endtask

    task automatic timer_overflow_and_cascade();
        logic [31:0] rd;
        logic        seen;
        bus_write(ACC_WORD, TM0_ADDR, timer_word(16'hFFF0, 2'd0, 1'b0, 1'b1));
        wait_cycles(20);
        bus_read(IE_IF_ADDR, rd);
        check("timer0 flag set", 1, rd[16 + IRQ_TIMER0]);
        bus_write(ACC_BYTE, ADDR_W'(TM0_ADDR + 2), 32'h0);     // stop timer 0
        bus_write(ACC_HALF, ADDR_W'(IE_IF_ADDR + 2), 32'h1 << (16 + IRQ_TIMER0));
        bus_read(IE_IF_ADDR, rd);
        check("timer0 flag cleared", 0, rd[16 + IRQ_TIMER0]);
        // timer 1 waits on timer 0 overflows
        bus_write(ACC_WORD, TM1_ADDR, timer_word(16'hFFFE, 2'd0, 1'b1, 1'b1));
        bus_write(ACC_WORD, TM0_ADDR, timer_word(16'hFFF0, 2'd0, 1'b0, 1'b0));
        wait_cycles(18);                     // timer 0 overflows every 16 cycles
        bus_read(IE_IF_ADDR, rd);
        check("timer1 flag after one overflow", 0, rd[16 + IRQ_TIMER1]);
        poll_flag(IRQ_TIMER1, 40, seen);
        if (!seen)
            report_problem("timer 1 flag never set in cascade mode");
        bus_write(ACC_BYTE, ADDR_W'(TM0_ADDR + 2), 32'h0);
        bus_write(ACC_BYTE, ADDR_W'(TM1_ADDR + 2), 32'h0);
        clear_flags();
    endtask

    task automatic irq_and_halt();
        logic [31:0] rd;
        int n;
        bus_write(ACC_WORD, IE_IF_ADDR, 32'h1 << IRQ_VBLANK);
        bus_write(ACC_WORD, IME_ADDR, 32'h1);
        pulse_line(1'b0);
        check("cpu_irq with ime", 1, cpu_irq);
        bus_write(ACC_HALF, ADDR_W'(IE_IF_ADDR + 2), 32'hFFFF_0000);
        check("cpu_irq after clear", 0, cpu_irq);
        bus_write(ACC_WORD, IME_ADDR, 32'h0);
        pulse_line(1'b0);
        check("cpu_irq without ime", 0, cpu_irq);
        bus_read(IE_IF_ADDR, rd);
        check("vblank flag without ime", 1, rd[16 + IRQ_VBLANK]);
        clear_flags();
        bus_write(ACC_WORD, IE_IF_ADDR, 32'h1 << IRQ_HBLANK);
        bus_write(ACC_BYTE, ADDR_W'(HALT_ADDR + 1), 32'h0);     // bit 15 clear, halt
        check("halt set", 1, halt);
        pulse_line(1'b1);
        n = 0;
        while (halt && n < 4) begin
            @(negedge clk16);
            n++;
        end
        if (halt)
            report_problem("halt stayed high after an enabled hblank flag");
        clear_flags();
    endtask

    task automatic keypad_state_and_irq();
        logic [31:0]         rd;
        logic [NUM_KEYS-1:0] k;
        logic [NUM_KEYS-1:0] mask;
        logic                seen;
        for (int i = 0; i < 4; i++) begin
            rd = next_rand();
            k  = rd[NUM_KEYS-1:0];
            @(negedge clk16);
            keys = k;
            wait_cycles(2);
            bus_read(KEY_ADDR, rd);
            check("key state", 32'({6'b0, ~k}), 32'(rd[15:0]));   // pressed reads 0
        end
        keys = '0;
        wait_cycles(3);
        clear_flags();
        // OR mode, key A only
        bus_write(ACC_WORD, KEY_ADDR, (32'h1 << KEY_IRQEN_BIT) | (32'h1 << KEY_MASK_LSB));
        @(negedge clk16);
        keys = 10'b00_0000_0001;
        poll_flag(IRQ_KEYPAD, 6, seen);
        if (!seen)
            report_problem("keypad flag not set for a masked key in OR mode");
        keys = '0;
        wait_cycles(3);
        clear_flags();
        // AND mode, at least two masked keys
        rd   = next_rand();
        mask = rd[NUM_KEYS-1:0] | 10'b11;
        bus_write(ACC_WORD, KEY_ADDR, (32'h1 << KEY_AND_BIT) | (32'h1 << KEY_IRQEN_BIT) |
                                      (32'(mask) << KEY_MASK_LSB));
        @(negedge clk16);
        keys = mask & ~10'b1;
        wait_cycles(6);
        bus_read(IE_IF_ADDR, rd);
        check("keypad AND partial press", 0, rd[16 + IRQ_KEYPAD]);
        keys = mask;
        poll_flag(IRQ_KEYPAD, 6, seen);
        if (!seen)
            report_problem("keypad flag not set with all masked keys pressed in AND mode");
        keys = '0;
        clear_flags();
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        resetn  = 1'b0;
        bus_ena = 1'b0;
        bus_rnw = 1'b1;
        bus_adr = '0;
        bus_acc = ACC_WORD;
        bus_din = '0;
        keys    = '0;
        vblank  = 1'b0;
        hblank  = 1'b0;

        reset_and_power_on();
        byte_enable_lanes();
        timer_overflow_and_cascade();
        irq_and_halt();
        keypad_state_and_irq();

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- design/gba_io_top.sv
// top of the I/O register block, wiring only
// vblank and hblank must be single-cycle pulses in the clk16 domain
`timescale 1ns/1ps

module gba_io_top
    import io_pkg::*;
(
    input  logic                clk16,
    input  logic                resetn,
    input  logic                bus_ena,
    input  logic                bus_rnw,
    input  logic [ADDR_W-1:0]   bus_adr,
    input  logic [1:0]          bus_acc,
    input  logic [DATA_W-1:0]   bus_din,
    input  logic [NUM_KEYS-1:0] keys,
    input  logic                vblank,
    input  logic                hblank,
    output logic                bus_done,
    output logic [DATA_W-1:0]   bus_dout,
    output logic                gba_on,
    output logic                cpu_irq,
    output logic                halt
);

    logic              core_on;
    logic [DATA_W-1:0] wdata;
    logic [3:0]        be;
    logic [1:0]        tm_wr;
    logic              key_wr, ie_if_wr, ime_wr, halt_wr;
    logic [DATA_W-1:0] tm0_rdata, tm1_rdata, key_rdata, ie_if_rdata, ime_rdata;
    logic              tm0_irq, tm1_irq, key_irq;

    io_ctrl i_io_ctrl (
        .clk16, .resetn, .bus_ena, .bus_rnw, .bus_adr, .bus_acc, .bus_din,
        .bus_done, .bus_dout, .gba_on, .core_on, .wdata, .be,
        .tm_wr, .key_wr, .ie_if_wr, .ime_wr, .halt_wr,
        .tm0_rdata, .tm1_rdata, .key_rdata, .ie_if_rdata, .ime_rdata
    );

    irq_ctrl i_irq_ctrl (
        .clk16, .core_on, .wdata, .be, .ie_if_wr, .ime_wr, .halt_wr,
        .vblank, .hblank, .tm0_irq, .tm1_irq, .key_irq,
        .ie_if_rdata, .ime_rdata, .cpu_irq, .halt
    );

    io_timers i_io_timers (
        .clk16, .core_on, .wdata, .be, .tm_wr,
        .tm0_rdata, .tm1_rdata, .tm0_irq, .tm1_irq
    );

    keypad i_keypad (
        .clk16, .core_on, .keys, .wdata, .be, .key_wr, .key_rdata, .key_irq
    );

endmodule

//--- design/keypad.sv
// key state and key interrupt control
// keys are active high at the port and read back active low
// the interrupt fires on the rising edge of the key condition only
`timescale 1ns/1ps

module keypad
    import io_pkg::*;
(
    input  logic                clk16,
    input  logic                core_on,
    input  logic [NUM_KEYS-1:0] keys,
    input  logic [DATA_W-1:0]   wdata,
    input  logic [3:0]          be,
    input  logic                key_wr,
    output logic [DATA_W-1:0]   key_rdata,
    output logic                key_irq
);

    logic [NUM_KEYS-1:0] keys_q;
    logic [NUM_KEYS-1:0] mask_q;
    logic [NUM_KEYS-1:0] hit;
    logic                irqen_q;
    logic                and_q;
    logic                cond;
    logic                cond_q;

    assign hit  = keys_q & mask_q;
    assign cond = and_q ? (mask_q != '0) && (hit == mask_q)   // all masked keys held
                        : |hit;

    always_ff @(posedge clk16) begin
        if (!core_on) begin
            keys_q  <= '0;
            mask_q  <= '0;
            irqen_q <= 1'b0;
            and_q   <= 1'b0;
            cond_q  <= 1'b0;
            key_irq <= 1'b0;
        end else begin
            keys_q <= keys;
            if (key_wr && be[2])
                mask_q[7:0] <= wdata[KEY_MASK_LSB +: 8];
            if (key_wr && be[3]) begin
                mask_q[NUM_KEYS-1:8] <= wdata[KEY_MASK_LSB+8 +: NUM_KEYS-8];
                irqen_q <= wdata[KEY_IRQEN_BIT];
                and_q   <= wdata[KEY_AND_BIT];
            end
            cond_q  <= cond;
            key_irq <= cond & ~cond_q & irqen_q;
        end
    end

    assign key_rdata = {and_q, irqen_q, {(KEY_IRQEN_BIT-KEY_MASK_LSB-NUM_KEYS){1'b0}}, mask_q,
                        {(16-NUM_KEYS){1'b0}}, ~keys_q};

endmodule

//--- design/io_timers.sv
// hardware timers 0 and 1, 16 bit up-counters with reload
// reload written while running only takes effect at the next overflow or start
// only timer 1 can cascade, timer 0 ignores its cascade bit
`timescale 1ns/1ps

module io_timers
    import io_pkg::*;
(
    input  logic              clk16,
    input  logic              core_on,
    input  logic [DATA_W-1:0] wdata,
    input  logic [3:0]        be,
    input  logic [1:0]        tm_wr,
    output logic [DATA_W-1:0] tm0_rdata,
    output logic [DATA_W-1:0] tm1_rdata,
    output logic              tm0_irq,
    output logic              tm1_irq
);

    logic              ovf   [2];     // overflow in this cycle
    logic              irq   [2];
    logic [DATA_W-1:0] rdata [2];

    for (genvar t = 0; t < 2; t++) begin : g_tm
        logic [15:0]         cnt_q;
        logic [15:0]         reload_q;
        logic [7:0]          ctrl_q;  // word bits 23:16
        logic [TM_PSC_W-1:0] psc_q;
        logic [15:0]         reload_new;
        logic [7:0]          ctrl_new;
        logic [TM_PSC_W-1:0] psc_mask;
        logic                running;
        logic                start;
        logic                tick;
        logic                step;

        // merge the lane writes
        always_comb begin
            reload_new = reload_q;
            ctrl_new   = ctrl_q;
            if (tm_wr[t]) begin
                if (be[0])
                    reload_new[7:0] = wdata[7:0];
                if (be[1])
                    reload_new[15:8] = wdata[15:8];
                if (be[2])
                    ctrl_new = wdata[TM_PRESCALE_LSB +: 8];
            end
        end

        assign running  = ctrl_q[TM_ENABLE_BIT - TM_PRESCALE_LSB];
        assign start    = ~running & ctrl_new[TM_ENABLE_BIT - TM_PRESCALE_LSB];
        assign psc_mask = TM_PSC_W'((1 << PRESCALE_SHIFT[ctrl_q[1:0]]) - 1);
        assign tick     = (psc_q & psc_mask) == psc_mask;

        if (t == 1) begin : g_casc
            assign step = running &
                (ctrl_q[TM_CASCADE_BIT - TM_PRESCALE_LSB] ? ovf[0] : tick);
        end else begin : g_free
            assign step = running & tick;
        end

        assign ovf[t]   = step & (cnt_q == 16'hFFFF);
        assign irq[t]   = ovf[t] & ctrl_q[TM_IRQEN_BIT - TM_PRESCALE_LSB];
        assign rdata[t] = {8'h00, ctrl_q, cnt_q};

        always_ff @(posedge clk16) begin
            if (!core_on) begin
                cnt_q    <= '0;
                reload_q <= '0;
                ctrl_q   <= '0;
                psc_q    <= '0;
            end else begin
                reload_q <= reload_new;
                ctrl_q   <= ctrl_new;
                if (start) begin
                    cnt_q <= reload_new;            // fresh start, prescaler realigned
                    psc_q <= '0;
                end else if (running) begin
                    psc_q <= psc_q + 1'b1;
                    if (step)
                        cnt_q <= ovf[t] ? reload_q : cnt_q + 1'b1;
                end
            end
        end
    end

    assign tm0_rdata = rdata[0];
    assign tm1_rdata = rdata[1];
    assign tm0_irq   = irq[0];
    assign tm1_irq   = irq[1];

endmodule

//--- design/irq_ctrl.sv
// interrupt enable, flags, master enable and halt
// a flag write clears bits written as one, a source pulse in the same cycle wins
// halt drops once any enabled flag is pending, regardless of the master enable
`timescale 1ns/1ps

module irq_ctrl
    import io_pkg::*;
(
    input  logic              clk16,
    input  logic              core_on,
    input  logic [DATA_W-1:0] wdata,
    input  logic [3:0]        be,
    input  logic              ie_if_wr,
    input  logic              ime_wr,
    input  logic              halt_wr,
    input  logic              vblank,
    input  logic              hblank,
    input  logic              tm0_irq,
    input  logic              tm1_irq,
    input  logic              key_irq,
    output logic [DATA_W-1:0] ie_if_rdata,
    output logic [DATA_W-1:0] ime_rdata,
    output logic              cpu_irq,
    output logic              halt
);

    logic [NUM_IRQ-1:0] ie_q;
    logic [NUM_IRQ-1:0] if_q;
    logic               ime_q;
    logic [NUM_IRQ-1:0] src;
    logic [NUM_IRQ-1:0] clr;
    logic [NUM_IRQ-1:0] pend;

    always_comb begin
        src = '0;
        src[IRQ_VBLANK] = vblank;
        src[IRQ_HBLANK] = hblank;
        src[IRQ_TIMER0] = tm0_irq;
        src[IRQ_TIMER1] = tm1_irq;
        src[IRQ_KEYPAD] = key_irq;
        for (int i = 0; i < NUM_IRQ; i++)
            clr[i] = ie_if_wr & be[2 + i / 8] & wdata[16 + i];  // write one to clear
    end

    assign pend    = ie_q & if_q;
    assign cpu_irq = ime_q & (|pend);

    always_ff @(posedge clk16) begin
        if (!core_on) begin
            ie_q  <= '0;
            if_q  <= '0;
            ime_q <= 1'b0;
            halt  <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_IRQ; i++) begin
                if (ie_if_wr && be[i / 8])
                    ie_q[i] <= wdata[i];
            end
            if_q <= src | (if_q & ~clr);
            if (ime_wr && be[0])
                ime_q <= wdata[0];
            if (halt_wr && be[1] && !wdata[15])     // bit 15 set would be stop
                halt <= 1'b1;
            else if (|pend)
                halt <= 1'b0;
        end
    end

    assign ie_if_rdata = {{(16-NUM_IRQ){1'b0}}, if_q, {(16-NUM_IRQ){1'b0}}, ie_q};
    assign ime_rdata   = {{(DATA_W-1){1'b0}}, ime_q};

    // the line only rises once the master enable was set or is being written
    a_irq_needs_ime: assert property (@(posedge clk16) disable iff (!core_on)
        $rose(cpu_irq) |-> $past(ime_q) || $past(ime_wr && be[0] && wdata[0]));

endmodule

//--- design/io_ctrl.sv
// bus front end of the I/O block: reset hold, decode, byte enables, read mux
// bus_ena is ignored until gba_on; every accepted access gets done one cycle later
// datapaths are reset by core_on, which trails gba_on by one cycle
`timescale 1ns/1ps

module io_ctrl
    import io_pkg::*;
(
    input  logic              clk16,
    input  logic              resetn,
    input  logic              bus_ena,
    input  logic              bus_rnw,
    input  logic [ADDR_W-1:0] bus_adr,
    input  logic [1:0]        bus_acc,
    input  logic [DATA_W-1:0] bus_din,
    output logic              bus_done,
    output logic [DATA_W-1:0] bus_dout,
    output logic              gba_on,
    output logic              core_on,
    output logic [DATA_W-1:0] wdata,
    output logic [3:0]        be,
    output logic [1:0]        tm_wr,
    output logic              key_wr,
    output logic              ie_if_wr,
    output logic              ime_wr,
    output logic              halt_wr,
    input  logic [DATA_W-1:0] tm0_rdata,
    input  logic [DATA_W-1:0] tm1_rdata,
    input  logic [DATA_W-1:0] key_rdata,
    input  logic [DATA_W-1:0] ie_if_rdata,
    input  logic [DATA_W-1:0] ime_rdata
);

    logic [$clog2(RESET_HOLD+1)-1:0] hold_cnt;
    logic              accept;
    logic              wr_acc;
    logic [ADDR_W-1:0] word_adr;
    logic [DATA_W-1:0] rd_mux;

    function automatic logic [3:0] calc_be(input logic [1:0] acc, input logic [1:0] adr);
        case (acc)
            ACC_BYTE: calc_be = 4'b0001 << adr;
            ACC_HALF: calc_be = adr[1] ? 4'b1100 : 4'b0011;
            ACC_WORD: calc_be = 4'b1111;
            default:  calc_be = 4'b0000;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reset hold, core switched on after RESET_HOLD edges

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            hold_cnt <= '0;
            gba_on   <= 1'b0;
            core_on  <= 1'b0;
        end else begin
            if (!gba_on) begin
                hold_cnt <= hold_cnt + 1'b1;
                if (hold_cnt == RESET_HOLD - 1)
                    gba_on <= 1'b1;
            end
            core_on <= gba_on;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode

    assign accept   = bus_ena & gba_on;
    assign wr_acc   = accept & ~bus_rnw;
    assign word_adr = {bus_adr[ADDR_W-1:2], 2'b00};
    assign wdata    = bus_din;                     // already on its byte lanes
    assign be       = calc_be(bus_acc, bus_adr[1:0]);

    assign tm_wr[0] = wr_acc & (word_adr == TM0_ADDR);
    assign tm_wr[1] = wr_acc & (word_adr == TM1_ADDR);
    assign key_wr   = wr_acc & (word_adr == KEY_ADDR);
    assign ie_if_wr = wr_acc & (word_adr == IE_IF_ADDR);
    assign ime_wr   = wr_acc & (word_adr == IME_ADDR);
    assign halt_wr  = wr_acc & (word_adr == HALT_ADDR);

    always_comb begin
        case (word_adr)
            TM0_ADDR:   rd_mux = tm0_rdata;
            TM1_ADDR:   rd_mux = tm1_rdata;
            KEY_ADDR:   rd_mux = key_rdata;
            IE_IF_ADDR: rd_mux = ie_if_rdata;
            IME_ADDR:   rd_mux = ime_rdata;
            default:    rd_mux = '0;                // unmapped, halt is write only
        endcase
    end

    always_ff @(posedge clk16) begin
        if (!resetn)
            bus_done <= 1'b0;
        else
            bus_done <= accept;
    end

    always_ff @(posedge clk16) begin
        if (accept)
            bus_dout <= bus_rnw ? rd_mux : '0;
    end

    a_one_strobe: assert property (@(posedge clk16) disable iff (!resetn)
        $onehot0({tm_wr, key_wr, ie_if_wr, ime_wr, halt_wr}));

    // master holds off the next access until done has been seen
    a_done_lat: assert property (@(posedge clk16) disable iff (!resetn)
        accept |=> bus_done && !bus_ena);

endmodule

//--- design/io_pkg.sv
// constants for the I/O register block: bus widths, offsets, fields
// offsets are byte offsets into the I/O page and are all word aligned
// only timers 0 and 1 exist, timers 2 and 3 decode as unmapped
package io_pkg;

    localparam int ADDR_W = 12;              // I/O offset on the bus
    localparam int DATA_W = 32;

    // access size codes on bus_acc
    localparam logic [1:0] ACC_BYTE = 2'd0;
    localparam logic [1:0] ACC_HALF = 2'd1;
    localparam logic [1:0] ACC_WORD = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // register word offsets

    localparam logic [ADDR_W-1:0] TM0_ADDR   = 12'h100; // reload / counter + control
    localparam logic [ADDR_W-1:0] TM1_ADDR   = 12'h104;
    localparam logic [ADDR_W-1:0] KEY_ADDR   = 12'h130; // key state + key control
    localparam logic [ADDR_W-1:0] IE_IF_ADDR = 12'h200; // enable low, flags high
    localparam logic [ADDR_W-1:0] IME_ADDR   = 12'h208;
    localparam logic [ADDR_W-1:0] HALT_ADDR  = 12'h300; // halt control on lane 1

    // timer control fields, bit positions in the word
    localparam int TM_PRESCALE_LSB = 16;     // 2 bit prescale select
    localparam int TM_CASCADE_BIT  = 18;
    localparam int TM_IRQEN_BIT    = 22;
    localparam int TM_ENABLE_BIT   = 23;

    // dividers 1, 64, 256, 1024
    localparam int PRESCALE_SHIFT [4] = '{0, 6, 8, 10};
    localparam int TM_PSC_W = PRESCALE_SHIFT[3];

    // keys in order A, B, select, start, right, left, up, down, R, L
    localparam int NUM_KEYS      = 10;
    localparam int KEY_MASK_LSB  = 16;
    localparam int KEY_IRQEN_BIT = 30;
    localparam int KEY_AND_BIT   = 31;

    //////////////////////////////////////////////////////////////////////
    // interrupt flag bits

    localparam int NUM_IRQ    = 14;
    localparam int IRQ_VBLANK = 0;
    localparam int IRQ_HBLANK = 1;
    localparam int IRQ_TIMER0 = 3;
    localparam int IRQ_TIMER1 = 4;
    localparam int IRQ_KEYPAD = 12;

    localparam int RESET_HOLD = 3;           // cycles from reset release to core on

endpackage
